//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+logic
logic/decode_pkg.sv
logic/stage_reg.sv
logic/inst_decoder.sv
logic/regfile.sv
logic/operand_fwd.sv
logic/branch_unit.sv
logic/id_stage.sv
bench/tb_id_stage.sv

//--- bench/tb_id_stage.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module tb_id_stage import decode_pkg::*; ();

    // flag bits: load, mem_we, sa, pc, imm, imm_zero, is_8, gr_we
    localparam logic [7:0] F_LOAD = 8'h80;
    localparam logic [7:0] F_MEMW = 8'h40;
    localparam logic [7:0] F_SA   = 8'h20;
    localparam logic [7:0] F_PC   = 8'h10;
    localparam logic [7:0] F_IMM  = 8'h08;
    localparam logic [7:0] F_IMMZ = 8'h04;
    localparam logic [7:0] F_IS8  = 8'h02;
    localparam logic [7:0] F_WE   = 8'h01;

    typedef struct {
        string     name;
        logic [31:0] word;
        logic [31:0] pc;
        fwd_src_t  exe;
        fwd_src_t  mem;
        fwd_src_t  wb;
        logic      ld;
        ds_to_es_t exp;
        br_bus_t   br;
    } entry_t;

    logic      clk;
    logic      reset;
    logic      fs_to_ds_valid;
    fs_to_ds_t fs_to_ds;
    logic      ds_allowin;
    logic      es_allowin;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es;
    br_bus_t   br_bus;
    rf_write_t ws_to_rf;
    fwd_src_t  exe_fwd;
    fwd_src_t  mem_fwd;
    fwd_src_t  wb_fwd;
    logic      exe_is_load;

    entry_t      tbl[$];
    logic [31:0] rv[1:8];
    logic [31:0] xd[1:5];
    integer      seed;
    int          n_tests;
    int          n_errors;

    id_stage dut0 (
        .clk(clk), .reset(reset), .fs_to_ds_valid(fs_to_ds_valid), .fs_to_ds(fs_to_ds),
        .ds_allowin(ds_allowin), .es_allowin(es_allowin), .ds_to_es_valid(ds_to_es_valid),
        .ds_to_es(ds_to_es), .br_bus(br_bus), .ws_to_rf(ws_to_rf), .exe_fwd(exe_fwd),
        .mem_fwd(mem_fwd), .wb_fwd(wb_fwd), .exe_is_load(exe_is_load)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic ctrl_t mk_ctrl(input int alu, input logic [7:0] f,
                                      input logic [4:0] dest, input logic rsv);
        ctrl_t c;
        c = '0;
        if (alu >= 0) begin
            c.alu_op[alu] = 1'b1;
        end
        {c.load_op, c.mem_we, c.src1_is_sa, c.src1_is_pc, c.src2_is_imm,
         c.src2_is_imm_zero, c.src2_is_8, c.gr_we} = f;
        c.dest     = dest;
        c.reserved = rsv;
        return c;
    endfunction

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input logic [5:0] fn);
        return {`OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic fwd_src_t fw(input logic [4:0] dest, input logic [31:0] data);
        fwd_src_t f;
        f.dest = dest;
        f.data = data;
        return f;
    endfunction

    // kind: 0 none, 1 pc-relative branch, 2 absolute jump, 3 register jump
    task automatic add_entry(input string name, input logic [31:0] word, input ctrl_t c,
                             input logic [31:0] rsv, input logic [31:0] rtv,
                             input fwd_src_t exe, input fwd_src_t mem, input fwd_src_t wb,
                             input logic ld, input int kind, input logic taken);
        entry_t      e;
        logic [31:0] slot;
        e.name = name;
        e.word = word;
        e.pc   = 32'h0040_0000 + 32'(tbl.size() * 16);
        e.exe  = exe;
        e.mem  = mem;
        e.wb   = wb;
        e.ld   = ld;
        e.exp.ctrl     = c;
        e.exp.imm      = word[15:0];
        e.exp.rs_value = rsv;
        e.exp.rt_value = rtv;
        e.exp.pc       = e.pc;
        slot = e.pc + 32'd4;
        e.br.stall = 1'b0;
        e.br.taken = taken;
        case (kind)
            2: e.br.target = {slot[31:28], word[25:0], 2'b00};
            3: e.br.target = rsv;
            default: e.br.target = slot + {{14{word[15]}}, word[15:0], 2'b00};
        endcase
        tbl.push_back(e);
    endtask

    task automatic build_table();
        ctrl_t    nb;
        fwd_src_t z;
        nb = mk_ctrl(-1, 8'h00, 5'd0, 1'b0);
        z  = '0;
        add_entry("addu", r_word(1, 2, 3, 0, `FN_ADDU), mk_ctrl(`ALU_ADD, F_WE, 3, 0),
                  rv[1], rv[2], z, z, z, 0, 0, 0);
        add_entry("subu", r_word(6, 7, 5, 0, `FN_SUBU), mk_ctrl(`ALU_SUB, F_WE, 5, 0),
                  rv[6], rv[7], z, z, z, 0, 0, 0);
        add_entry("slt", r_word(1, 2, 8, 0, `FN_SLT), mk_ctrl(`ALU_SLT, F_WE, 8, 0),
                  rv[1], rv[2], z, z, z, 0, 0, 0);
        add_entry("ori", i_word(`OP_ORI, 1, 4, 16'h00f0),
                  mk_ctrl(`ALU_OR, F_IMMZ | F_WE, 4, 0), rv[1], rv[4], z, z, z, 0, 0, 0);
        add_entry("sll", r_word(0, 2, 3, 5, `FN_SLL), mk_ctrl(`ALU_SLL, F_SA | F_WE, 3, 0),
                  32'd0, rv[2], z, z, z, 0, 0, 0);
        add_entry("lui", i_word(`OP_LUI, 0, 6, 16'h1234),
                  mk_ctrl(`ALU_LUI, F_IMM | F_WE, 6, 0), 32'd0, rv[6], z, z, z, 0, 0, 0);
        add_entry("lw", i_word(`OP_LW, 1, 7, 16'd8),
                  mk_ctrl(`ALU_ADD, F_LOAD | F_IMM | F_WE, 7, 0), rv[1], rv[7],
                  z, z, z, 0, 0, 0);
        add_entry("sw", i_word(`OP_SW, 1, 2, 16'd12), mk_ctrl(`ALU_ADD, F_MEMW | F_IMM, 0, 0),
                  rv[1], rv[2], z, z, z, 0, 0, 0);
        add_entry("reserved", 32'hfc00_0000, mk_ctrl(-1, 8'h00, 0, 1), 32'd0, 32'd0,
                  z, z, z, 0, 0, 0);
        add_entry("fwd_exe", r_word(1, 2, 3, 0, `FN_ADDU), mk_ctrl(`ALU_ADD, F_WE, 3, 0),
                  xd[1], rv[2], fw(1, xd[1]), fw(1, xd[2]), fw(1, xd[3]), 0, 0, 0);
        add_entry("fwd_mem", r_word(1, 2, 3, 0, `FN_ADDU), mk_ctrl(`ALU_ADD, F_WE, 3, 0),
                  xd[2], rv[2], z, fw(1, xd[2]), fw(1, xd[3]), 0, 0, 0);
        add_entry("fwd_wb", r_word(1, 2, 3, 0, `FN_ADDU), mk_ctrl(`ALU_ADD, F_WE, 3, 0),
                  xd[3], rv[2], z, z, fw(1, xd[3]), 0, 0, 0);
        // both sources read r0 while every stage offers dest 0
        add_entry("fwd_r0", r_word(0, 0, 3, 0, `FN_ADDU), mk_ctrl(`ALU_ADD, F_WE, 3, 0),
                  32'd0, 32'd0, fw(0, xd[1]), fw(0, xd[2]), fw(0, xd[3]), 0, 0, 0);
        add_entry("load_use", r_word(1, 2, 3, 0, `FN_ADDU), mk_ctrl(`ALU_ADD, F_WE, 3, 0),
                  rv[1], xd[4], fw(2, xd[4]), z, z, 1, 0, 0);
        add_entry("beq_t", i_word(`OP_BEQ, 1, 1, 16'hfff8), nb, rv[1], rv[1], z, z, z, 0, 1,
                  rv[1] == rv[1]);
        add_entry("beq_nt", i_word(`OP_BEQ, 1, 2, 16'h0010), nb, rv[1], rv[2], z, z, z, 0, 1,
                  rv[1] == rv[2]);
        add_entry("bne_t", i_word(`OP_BNE, 1, 2, 16'h0020), nb, rv[1], rv[2], z, z, z, 0, 1,
                  rv[1] != rv[2]);
        add_entry("bne_nt", i_word(`OP_BNE, 1, 1, 16'h0020), nb, rv[1], rv[1], z, z, z, 0, 1,
                  rv[1] != rv[1]);
        add_entry("bgez", i_word(`OP_REGIMM, 7, `RT_BGEZ, 16'h8000), nb, rv[7], rv[1],
                  z, z, z, 0, 1, $signed(rv[7]) >= 0);
        add_entry("bgtz", i_word(`OP_BGTZ, 5, 0, 16'h0004), nb, rv[5], 32'd0, z, z, z, 0, 1,
                  $signed(rv[5]) > 0);
        add_entry("blez", i_word(`OP_BLEZ, 5, 0, 16'h0004), nb, rv[5], 32'd0, z, z, z, 0, 1,
                  $signed(rv[5]) <= 0);
        add_entry("bltz", i_word(`OP_REGIMM, 6, `RT_BLTZ, 16'hff00), nb, rv[6], 32'd0,
                  z, z, z, 0, 1, $signed(rv[6]) < 0);
        add_entry("j", {`OP_J, 26'h000_1234}, nb, 32'd0, 32'd0, z, z, z, 0, 2, 1);
        add_entry("jal", {`OP_JAL, 26'h000_5678},
                  mk_ctrl(`ALU_ADD, F_PC | F_IS8 | F_WE, `LINK_REG, 0), 32'd0, 32'd0,
                  z, z, z, 0, 2, 1);
        add_entry("jr", r_word(1, 0, 0, 0, `FN_JR), nb, rv[1], 32'd0, z, z, z, 0, 3, 1);
        add_entry("beq_load_use", i_word(`OP_BEQ, 1, 1, 16'h0040), nb, xd[5], xd[5],
                  fw(1, xd[5]), z, z, 1, 1, 1);
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        n_errors++;
    endtask

    task automatic check_bus(input string name, input ds_to_es_t exp);
        n_tests++;
        if (ds_to_es !== exp) begin
            report_error($sformatf("CHECK FAILED %s bus: expected %h, actual %h",
                                   name, exp, ds_to_es));
        end else begin
            $display("ok %s bus", name);
        end
    endtask

    task automatic check_branch(input string name, input br_bus_t exp);
        n_tests++;
        if (br_bus.taken !== exp.taken || br_bus.stall !== exp.stall ||
            (exp.taken && br_bus.target !== exp.target)) begin
            report_error($sformatf("CHECK FAILED %s branch: expected %h, actual %h",
                                   name, exp, br_bus));
        end else begin
            $display("ok %s branch", name);
        end
    endtask

    task automatic wait_allowin(input string name);
        int n;
        n = 0;
        while (ds_allowin !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (ds_allowin !== 1'b1) begin
            report_error($sformatf("%s: stage never became free to accept", name));
        end
    endtask

    task automatic wait_out_valid(input string name);
        int n;
        n = 0;
        while (ds_to_es_valid !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (ds_to_es_valid !== 1'b1) begin
            report_error($sformatf("%s: instruction never left toward execute", name));
        end
    endtask

    // the load flag is raised only once the word sits in decode
    task automatic drive_entry(input entry_t e);
        fs_to_ds_valid = 1'b1;
        fs_to_ds       = {e.word, e.pc};
        exe_fwd        = e.exe;
        mem_fwd        = e.mem;
        wb_fwd         = e.wb;
        exe_is_load    = 1'b0;
    endtask

    initial begin
        br_bus_t sb;
        seed = 84745;
        n_tests = 0;
        n_errors = 0;
        reset = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds = '0;
        es_allowin = 1'b1;
        ws_to_rf = '0;
        exe_fwd = '0;
        mem_fwd = '0;
        wb_fwd = '0;
        exe_is_load = 1'b0;

        repeat (5) @(negedge clk);
        if (ds_to_es_valid !== 1'b0 || br_bus.taken !== 1'b0 || ds_allowin !== 1'b1) begin
            report_error("reset: outputs not idle while reset is held");
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (ds_to_es_valid !== 1'b0 || br_bus.taken !== 1'b0 || ds_allowin !== 1'b1) begin
            report_error("reset: outputs not idle after reset release");
        end

        // preload r1..r8, with fixed sign cases for the branch tests
        for (int i = 1; i <= 8; i++) begin
            rv[i] = $random(seed);
        end
        for (int i = 1; i <= 5; i++) begin
            xd[i] = $random(seed);
        end
        rv[2] = rv[1] ^ 32'd1;
        rv[5] = 32'd0;
        rv[6] = rv[6] | 32'h8000_0000;
        rv[7] = (rv[7] & 32'h7fff_ffff) | 32'd1;
        for (int i = 1; i <= 8; i++) begin
            ws_to_rf = '{we: 1'b1, addr: 5'(i), data: rv[i]};
            @(negedge clk);
        end
        ws_to_rf = '0;
        build_table();

        foreach (tbl[i]) begin
            wait_allowin(tbl[i].name);
            drive_entry(tbl[i]);
            @(posedge clk);
            @(negedge clk);
            fs_to_ds_valid = 1'b0;
            if (tbl[i].ld) begin
                exe_is_load = 1'b1;
                sb = tbl[i].br;
                sb.stall = sb.taken;
                repeat (2) begin
                    @(negedge clk);
                    if (ds_to_es_valid !== 1'b0 || ds_allowin !== 1'b0) begin
                        report_error($sformatf("%s: load-use hazard did not hold the stage",
                                               tbl[i].name));
                    end
                end
                check_branch({tbl[i].name, "_held"}, sb);
                // execute busy, so the released word stays in decode
                exe_is_load = 1'b0;
                es_allowin  = 1'b0;
                @(negedge clk);
            end
            wait_out_valid(tbl[i].name);
            check_bus(tbl[i].name, tbl[i].exp);
            check_branch(tbl[i].name, tbl[i].br);
            if (tbl[i].ld) begin
                es_allowin = 1'b1;
                @(negedge clk);
            end
        end

        // back-pressure: entry 0 held while fetch offers entry 1
        @(negedge clk);
        es_allowin = 1'b0;
        drive_entry(tbl[0]);
        @(posedge clk);
        @(negedge clk);
        drive_entry(tbl[1]);
        repeat (3) begin
            if (ds_allowin !== 1'b0 || ds_to_es_valid !== 1'b1) begin
                report_error("backpressure: stage accepted or dropped under a full execute");
            end
            check_bus("backpressure_hold", tbl[0].exp);
            @(negedge clk);
        end
        es_allowin = 1'b1;
        @(posedge clk);
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        wait_out_valid("backpressure_next");
        check_bus("backpressure_next", tbl[1].exp);

        $display("tests: %0d, failed checks: %0d", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- logic/branch_unit.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module branch_unit import decode_pkg::*; (
    input  br_kind_t           br_kind,
    input  logic               ds_valid,
    input  logic               load_stall,
    input  logic [`WORD_W-1:0] pc,
    input  logic [15:0]        imm,
    input  logic [25:0]        jidx,
    input  logic [`WORD_W-1:0] rs_value,
    input  logic [`WORD_W-1:0] rt_value,
    output br_bus_t            br_bus
);

    logic [`WORD_W-1:0] slot_pc;
    logic [`WORD_W-1:0] br_offset;
    logic               rs_eq_rt;
    logic               rs_neg;
    logic               rs_zero;
    logic               cond;

    assign slot_pc   = pc + 32'd4;
    assign br_offset = {{14{imm[15]}}, imm, 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);
    assign rs_neg    = rs_value[`WORD_W-1];
    assign rs_zero   = (rs_value == '0);

    always_comb begin
        case (br_kind)
            BR_BEQ:   cond = rs_eq_rt;
            BR_BNE:   cond = ~rs_eq_rt;
            BR_BGEZ:  cond = ~rs_neg;
            BR_BGTZ:  cond = ~rs_neg & ~rs_zero;
            BR_BLEZ:  cond = rs_neg | rs_zero;
            BR_BLTZ:  cond = rs_neg;
            BR_J_ABS: cond = 1'b1;
            BR_J_REG: cond = 1'b1;
            default:  cond = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind)
            BR_J_ABS: br_bus.target = {slot_pc[31:28], jidx, 2'b00};
            BR_J_REG: br_bus.target = rs_value;
            default:  br_bus.target = slot_pc + br_offset;
        endcase
    end

    assign br_bus.taken = cond & ds_valid;
    // fetch must not redirect on a stale operand
    assign br_bus.stall = br_bus.taken & load_stall;

endmodule

//--- logic/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define WORD_W    32
`define REG_AW    5
`define LINK_REG  5'd31

// primary opcodes
`define OP_SPECIAL 6'h00
`define OP_REGIMM  6'h01
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_BLEZ    6'h06
`define OP_BGTZ    6'h07
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0a
`define OP_SLTIU   6'h0b
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_XORI    6'h0e
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

// special function codes
`define FN_SLL     6'h00
`define FN_SRL     6'h02
`define FN_SRA     6'h03
`define FN_SLLV    6'h04
`define FN_SRLV    6'h06
`define FN_SRAV    6'h07
`define FN_JR      6'h08
`define FN_JALR    6'h09
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_NOR     6'h27
`define FN_SLT     6'h2a
`define FN_SLTU    6'h2b

// regimm selects, carried in rt
`define RT_BLTZ    5'h00
`define RT_BGEZ    5'h01
`define RT_BLTZAL  5'h10
`define RT_BGEZAL  5'h11

// bit positions in the one-hot alu op
`define ALU_ADD    0
`define ALU_SUB    1
`define ALU_SLT    2
`define ALU_SLTU   3
`define ALU_AND    4
`define ALU_NOR    5
`define ALU_OR     6
`define ALU_XOR    7
`define ALU_SLL    8
`define ALU_SRL    9
`define ALU_SRA    10
`define ALU_LUI    11

`endif

//--- logic/decode_pkg.sv
`include "decode_defines.svh"

package decode_pkg;

    typedef struct packed {
        logic [5:0]         op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [`REG_AW-1:0] rd;
        logic [4:0]         sa;
        logic [5:0]         func;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]         op;
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        logic [15:0]        imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] jidx;
    } j_fmt_t;

    // one instruction word, three ways to read it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef struct packed {
        inst_u              inst;
        logic [`WORD_W-1:0] pc;
    } fs_to_ds_t;

    // one-hot, bit 0 is add
    typedef logic [11:0] alu_op_t;

    typedef struct packed {
        alu_op_t            alu_op;
        logic               load_op;
        logic               mem_we;
        logic               src1_is_sa;
        logic               src1_is_pc;
        logic               src2_is_imm;
        logic               src2_is_imm_zero;
        logic               src2_is_8;
        logic               gr_we;
        logic [`REG_AW-1:0] dest;
        logic               reserved;
    } ctrl_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BGEZ,
        BR_BGTZ,
        BR_BLEZ,
        BR_BLTZ,
        BR_J_ABS,
        BR_J_REG
    } br_kind_t;

    typedef struct packed {
        ctrl_t              ctrl;
        logic [15:0]        imm;
        logic [`WORD_W-1:0] rs_value;
        logic [`WORD_W-1:0] rt_value;
        logic [`WORD_W-1:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] addr;
        logic [`WORD_W-1:0] data;
    } rf_write_t;

    typedef struct packed {
        logic [`REG_AW-1:0] dest;
        logic [`WORD_W-1:0] data;
    } fwd_src_t;

    typedef struct packed {
        logic               stall;
        logic               taken;
        logic [`WORD_W-1:0] target;
    } br_bus_t;

endpackage

//--- logic/id_stage.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module id_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds,
    output logic      ds_allowin,
    input  logic      es_allowin,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es,
    output br_bus_t   br_bus,
    input  rf_write_t ws_to_rf,
    input  fwd_src_t  exe_fwd,
    input  fwd_src_t  mem_fwd,
    input  fwd_src_t  wb_fwd,
    input  logic      exe_is_load
);

    logic               ds_valid;
    fs_to_ds_t          held;
    ctrl_t              ctrl;
    br_kind_t           br_kind;
    logic               rt_used;
    logic               load_stall;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [`WORD_W-1:0] rf_rs;
    logic [`WORD_W-1:0] rf_rt;
    logic [`WORD_W-1:0] rs_value;
    logic [`WORD_W-1:0] rt_value;

    assign rs = held.inst.r_fmt.rs;
    assign rt = held.inst.r_fmt.rt;

    stage_reg u_stage_reg (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (fs_to_ds_valid),
        .in_data    (fs_to_ds),
        .ready_go   (~load_stall),
        .out_allowin(es_allowin),
        .allowin    (ds_allowin),
        .out_valid  (ds_to_es_valid),
        .ds_valid   (ds_valid),
        .held       (held)
    );

    inst_decoder u_decoder (
        .inst   (held.inst),
        .ctrl   (ctrl),
        .br_kind(br_kind),
        .rt_used(rt_used)
    );

    regfile u_regfile (
        .clk   (clk),
        .raddr1(rs),
        .raddr2(rt),
        .rdata1(rf_rs),
        .rdata2(rf_rt),
        .wr    (ws_to_rf)
    );

    operand_fwd u_fwd (
        .rs         (rs),
        .rt         (rt),
        .rt_used    (rt_used),
        .rf_rs      (rf_rs),
        .rf_rt      (rf_rt),
        .exe_fwd    (exe_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .exe_is_load(exe_is_load),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall)
    );

    branch_unit u_branch (
        .br_kind   (br_kind),
        .ds_valid  (ds_valid),
        .load_stall(load_stall),
        .pc        (held.pc),
        .imm       (held.inst.i_fmt.imm),
        .jidx      (held.inst.j_fmt.jidx),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .br_bus    (br_bus)
    );

    // bundle for execute
    assign ds_to_es.ctrl     = ctrl;
    assign ds_to_es.imm      = held.inst.i_fmt.imm;
    assign ds_to_es.rs_value = rs_value;
    assign ds_to_es.rt_value = rt_value;
    assign ds_to_es.pc       = held.pc;

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module inst_decoder import decode_pkg::*; (
    input  inst_u    inst,
    output ctrl_t    ctrl,
    output br_kind_t br_kind,
    output logic     rt_used
);

    logic [5:0]         op;
    logic [5:0]         func;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [`REG_AW-1:0] rd;
    logic               special;
    logic               sa_zero;
    logic               rs_zero;
    logic               inst_addu, inst_subu, inst_slt, inst_sltu;
    logic               inst_and, inst_or, inst_xor, inst_nor;
    logic               inst_sll, inst_srl, inst_sra;
    logic               inst_sllv, inst_srlv, inst_srav;
    logic               inst_jr, inst_jalr;
    logic               inst_addiu, inst_slti, inst_sltiu;
    logic               inst_andi, inst_ori, inst_xori, inst_lui;
    logic               inst_lw, inst_sw;
    logic               inst_beq, inst_bne, inst_blez, inst_bgtz;
    logic               inst_bltz, inst_bgez, inst_bltzal, inst_bgezal;
    logic               inst_j, inst_jal;
    logic               dst_is_r31;
    logic               dst_is_rt;
    logic               dst_is_rd;
    logic               no_write_ok;

    assign op      = inst.i_fmt.op;
    assign func    = inst.r_fmt.func;
    assign rs      = inst.r_fmt.rs;
    assign rt      = inst.i_fmt.rt;
    assign rd      = inst.r_fmt.rd;
    assign special = (op == `OP_SPECIAL);
    assign sa_zero = (inst.r_fmt.sa == 5'd0);
    assign rs_zero = (rs == 5'd0);

    assign inst_addu   = special & (func == `FN_ADDU) & sa_zero;
    assign inst_subu   = special & (func == `FN_SUBU) & sa_zero;
    assign inst_slt    = special & (func == `FN_SLT)  & sa_zero;
    assign inst_sltu   = special & (func == `FN_SLTU) & sa_zero;
    assign inst_and    = special & (func == `FN_AND)  & sa_zero;
    assign inst_or     = special & (func == `FN_OR)   & sa_zero;
    assign inst_xor    = special & (func == `FN_XOR)  & sa_zero;
    assign inst_nor    = special & (func == `FN_NOR)  & sa_zero;
    // immediate shifts leave rs empty
    assign inst_sll    = special & (func == `FN_SLL)  & rs_zero;
    assign inst_srl    = special & (func == `FN_SRL)  & rs_zero;
    assign inst_sra    = special & (func == `FN_SRA)  & rs_zero;
    assign inst_sllv   = special & (func == `FN_SLLV) & sa_zero;
    assign inst_srlv   = special & (func == `FN_SRLV) & sa_zero;
    assign inst_srav   = special & (func == `FN_SRAV) & sa_zero;
    assign inst_jr     = special & (func == `FN_JR) & (rt == 5'd0) & (rd == 5'd0) & sa_zero;
    assign inst_jalr   = special & (func == `FN_JALR) & (rt == 5'd0) & sa_zero;

    assign inst_addiu  = (op == `OP_ADDIU);
    assign inst_slti   = (op == `OP_SLTI);
    assign inst_sltiu  = (op == `OP_SLTIU);
    assign inst_andi   = (op == `OP_ANDI);
    assign inst_ori    = (op == `OP_ORI);
    assign inst_xori   = (op == `OP_XORI);
    assign inst_lui    = (op == `OP_LUI) & rs_zero;
    assign inst_lw     = (op == `OP_LW);
    assign inst_sw     = (op == `OP_SW);
    assign inst_beq    = (op == `OP_BEQ);
    assign inst_bne    = (op == `OP_BNE);
    assign inst_blez   = (op == `OP_BLEZ) & (rt == 5'd0);
    assign inst_bgtz   = (op == `OP_BGTZ) & (rt == 5'd0);
    assign inst_bltz   = (op == `OP_REGIMM) & (rt == `RT_BLTZ);
    assign inst_bgez   = (op == `OP_REGIMM) & (rt == `RT_BGEZ);
    assign inst_bltzal = (op == `OP_REGIMM) & (rt == `RT_BLTZAL);
    assign inst_bgezal = (op == `OP_REGIMM) & (rt == `RT_BGEZAL);
    assign inst_j      = (inst.j_fmt.op == `OP_J);
    assign inst_jal    = (inst.j_fmt.op == `OP_JAL);

    // link instructions compute pc + 8 through the adder
    assign ctrl.alu_op[`ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw |
                                    inst_jal | inst_jalr | inst_bgezal | inst_bltzal;
    assign ctrl.alu_op[`ALU_SUB]  = inst_subu;
    assign ctrl.alu_op[`ALU_SLT]  = inst_slt | inst_slti;
    assign ctrl.alu_op[`ALU_SLTU] = inst_sltu | inst_sltiu;
    assign ctrl.alu_op[`ALU_AND]  = inst_and | inst_andi;
    assign ctrl.alu_op[`ALU_NOR]  = inst_nor;
    assign ctrl.alu_op[`ALU_OR]   = inst_or | inst_ori;
    assign ctrl.alu_op[`ALU_XOR]  = inst_xor | inst_xori;
    assign ctrl.alu_op[`ALU_SLL]  = inst_sll | inst_sllv;
    assign ctrl.alu_op[`ALU_SRL]  = inst_srl | inst_srlv;
    assign ctrl.alu_op[`ALU_SRA]  = inst_sra | inst_srav;
    assign ctrl.alu_op[`ALU_LUI]  = inst_lui;

    assign ctrl.load_op          = inst_lw;
    assign ctrl.mem_we           = inst_sw;
    assign ctrl.src1_is_sa       = inst_sll | inst_srl | inst_sra;
    assign ctrl.src1_is_pc       = dst_is_r31 | inst_jalr;
    assign ctrl.src2_is_imm      = inst_addiu | inst_slti | inst_sltiu | inst_lui |
                                   inst_lw | inst_sw;
    assign ctrl.src2_is_imm_zero = inst_andi | inst_ori | inst_xori;
    assign ctrl.src2_is_8        = dst_is_r31 | inst_jalr;

    assign dst_is_r31 = inst_jal | inst_bgezal | inst_bltzal;
    assign dst_is_rt  = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori |
                        inst_xori | inst_lui | inst_lw;
    assign dst_is_rd  = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and |
                        inst_or | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra |
                        inst_sllv | inst_srlv | inst_srav | inst_jalr;

    assign ctrl.gr_we = dst_is_r31 | dst_is_rt | dst_is_rd;
    assign ctrl.dest  = dst_is_r31 ? `LINK_REG :
                        dst_is_rt  ? rt        :
                        dst_is_rd  ? rd        : 5'd0;

    // kept words that write no register
    assign no_write_ok   = inst_sw | inst_beq | inst_bne | inst_blez | inst_bgtz |
                           inst_bltz | inst_bgez | inst_j | inst_jr;
    assign ctrl.reserved = ~(ctrl.gr_we | no_write_ok);

    assign rt_used = (dst_is_rd & ~inst_jalr) | inst_beq | inst_bne | inst_sw;

    always_comb begin
        if (inst_beq) begin
            br_kind = BR_BEQ;
        end else if (inst_bne) begin
            br_kind = BR_BNE;
        end else if (inst_bgez | inst_bgezal) begin
            br_kind = BR_BGEZ;
        end else if (inst_bgtz) begin
            br_kind = BR_BGTZ;
        end else if (inst_blez) begin
            br_kind = BR_BLEZ;
        end else if (inst_bltz | inst_bltzal) begin
            br_kind = BR_BLTZ;
        end else if (inst_j | inst_jal) begin
            br_kind = BR_J_ABS;
        end else if (inst_jr | inst_jalr) begin
            br_kind = BR_J_REG;
        end else begin
            br_kind = BR_NONE;
        end
    end

endmodule

//--- logic/operand_fwd.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module operand_fwd import decode_pkg::*; (
    input  logic [`REG_AW-1:0] rs,
    input  logic [`REG_AW-1:0] rt,
    input  logic               rt_used,
    input  logic [`WORD_W-1:0] rf_rs,
    input  logic [`WORD_W-1:0] rf_rt,
    input  fwd_src_t           exe_fwd,
    input  fwd_src_t           mem_fwd,
    input  fwd_src_t           wb_fwd,
    input  logic               exe_is_load,
    output logic [`WORD_W-1:0] rs_value,
    output logic [`WORD_W-1:0] rt_value,
    output logic               load_stall
);

    logic exe_hits_rs;
    logic exe_hits_rt;

    function automatic logic hit(input fwd_src_t src, input logic [`REG_AW-1:0] idx);
        hit = (src.dest != 5'd0) && (src.dest == idx);
    endfunction

    // youngest producer first
    function automatic logic [`WORD_W-1:0] pick(input logic [`REG_AW-1:0] idx,
                                                input logic [`WORD_W-1:0] rf_val);
        if (hit(exe_fwd, idx)) begin
            pick = exe_fwd.data;
        end else if (hit(mem_fwd, idx)) begin
            pick = mem_fwd.data;
        end else if (hit(wb_fwd, idx)) begin
            pick = wb_fwd.data;
        end else begin
            pick = rf_val;
        end
    endfunction

    always_comb begin
        rs_value = pick(rs, rf_rs);
        rt_value = rt_used ? pick(rt, rf_rt) : rf_rt;
    end

    assign exe_hits_rs = hit(exe_fwd, rs);
    assign exe_hits_rt = hit(exe_fwd, rt) & rt_used;
    // load data not ready until mem
    assign load_stall  = exe_is_load & (exe_hits_rs | exe_hits_rt);

endmodule

//--- logic/regfile.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module regfile import decode_pkg::*; (
    input  logic               clk,
    input  logic [`REG_AW-1:0] raddr1,
    input  logic [`REG_AW-1:0] raddr2,
    output logic [`WORD_W-1:0] rdata1,
    output logic [`WORD_W-1:0] rdata2,
    input  rf_write_t          wr
);

    logic [`WORD_W-1:0] regs [0:31];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != 5'd0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- logic/stage_reg.sv
`timescale 1ns/1ps

module stage_reg import decode_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  fs_to_ds_t in_data,
    input  logic      ready_go,
    input  logic      out_allowin,
    output logic      allowin,
    output logic      out_valid,
    output logic      ds_valid,
    output fs_to_ds_t held
);

    logic valid_q;

    // free when empty, or when the held word leaves this cycle
    assign allowin   = ~valid_q | (ready_go & out_allowin);
    assign out_valid = valid_q & ready_go;
    assign ds_valid  = valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (allowin) begin
            valid_q <= in_valid;
        end
    end

    // only a real handshake replaces the word
    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            held <= in_data;
        end
    end

endmodule
